//--- coffee_params.svh
`ifndef COFFEE_PARAMS_SVH
`define COFFEE_PARAMS_SVH

// ====================
// Brew timing
// ====================

// Clock cycles per brew second, kept small for short simulations
`define COFFEE_TICKS_PER_SEC 8

// Seconds an ingredient error stays on the display after a refused start
`define COFFEE_ING_HOLD_SECS 2

// ====================
// Recipe table
// ====================

// Five drink types times three sizes
`define COFFEE_RECIPES 15

`endif

//--- coffee_pkg.sv
package coffee_pkg;

    // One entry of the recipe table, times are in brew seconds
    typedef struct packed {
        logic       load_filter;
        logic [3:0] pour_time;
        logic [3:0] hot_water_time;
        logic [3:0] grinder_time;
        logic [3:0] cocoa_time;
        logic       add_creamer;
    } recipe_t;

    typedef struct packed {
        logic       flavor;
        logic [2:0] drink_type;
        logic [1:0] size;
    } selection_t;

    typedef enum logic [1:0] {
        ST_SELECT = 2'd0,
        ST_WAIT   = 2'd1,
        ST_BREW   = 2'd2
    } sys_state_t;

    // Brew phases in the order they run
    typedef enum logic [2:0] {
        PH_PAPER = 3'd0,
        PH_GRIND = 3'd1,
        PH_COCOA = 3'd2,
        PH_POUR  = 3'd3,
        PH_WATER = 3'd4,
        PH_DONE  = 3'd5
    } phase_t;

    typedef logic [15:0] err_mask_t;

    // Error mask bit numbers
    localparam int ERR_PAPER_NOT_INST = 0;
    localparam int ERR_PAPER_EMPTY    = 1;
    localparam int ERR_NO_COFFEE0     = 2;
    localparam int ERR_NO_COFFEE1     = 3;
    localparam int ERR_NO_CREAMER     = 4;
    localparam int ERR_NO_CHOC        = 5;
    localparam int ERR_PRESS_FAULT    = 6;
    localparam int ERR_PRESS_HIGH     = 7;
    localparam int ERR_STATUS_BAD     = 8;

    typedef struct packed {
        logic [1:0] paper_level;
        logic       bin0_empty;
        logic       bin1_empty;
        logic       creamer_empty;
        logic       choc_empty;
        logic [1:0] pressure;
        logic       temp_ready;
        logic       status;
    } sensors_t;

    typedef struct packed {
        logic heat;
        logic pourover;
        logic water;
        logic grinder0;
        logic grinder1;
        logic paper;
        logic cocoa;
        logic creamer;
    } actuators_t;

    // Raw button levels and single-cycle press pulses
    typedef struct packed {
        logic flavor;
        logic drink_type;
        logic size;
        logic start;
    } buttons_t;

endpackage

//--- button_edges.sv
`timescale 1ns/10ps

module button_edges
    import coffee_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  buttons_t buttons,
    output buttons_t presses
);

    buttons_t prev;
    logic     armed;

    // Previous sample of every button
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev  <= '0;
            armed <= 1'b0;
        end else begin
            prev  <= buttons;
            // One sample taken, edges are now meaningful
            armed <= 1'b1;
        end
    end

    // Rising edge of each button, suppressed until the first sample
    always_comb begin
        presses = buttons_t'(buttons & ~prev & {$bits(buttons_t){armed}});
    end

endmodule

//--- selection_ctrl.sv
`timescale 1ns/10ps
`include "coffee_params.svh"

module selection_ctrl
    import coffee_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  buttons_t   presses,
    input  logic       busy,
    output selection_t sel,
    output recipe_t    recipe
);

    logic [$bits(recipe_t)-1:0] recipe_rom [`COFFEE_RECIPES];
    logic [3:0]                 rom_idx;

    // ====================
    // Selection registers
    // ====================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else if (!busy) begin
            if (presses.flavor)
                sel.flavor <= ~sel.flavor;
            // Type wraps after 4, size wraps after 2
            if (presses.drink_type)
                sel.drink_type <= (sel.drink_type == 3'd4) ? 3'd0 : sel.drink_type + 3'd1;
            if (presses.size)
                sel.size <= (sel.size == 2'd2) ? 2'd0 : sel.size + 2'd1;
        end
    end

    // ====================
    // Recipe table
    // ====================
    initial begin
        $readmemh("recipes.hex", recipe_rom);
    end

    // Row is type * 3 + size
    always_comb begin
        rom_idx = ({1'b0, sel.drink_type} * 4'd3) + {2'b00, sel.size};
        recipe  = recipe_t'(recipe_rom[rom_idx]);
    end

endmodule

//--- fault_monitor.sv
`timescale 1ns/10ps
`include "coffee_params.svh"

module fault_monitor
    import coffee_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  sensors_t   sensors,
    input  buttons_t   presses,
    input  selection_t sel,
    input  recipe_t    recipe,
    input  logic       busy,
    output logic       sys_fault,
    output logic       start_grant,
    output err_mask_t  err_mask
);

    localparam int TICK_W = $clog2(`COFFEE_TICKS_PER_SEC + 1);
    localparam int HOLD_W = $clog2(`COFFEE_ING_HOLD_SECS + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`COFFEE_TICKS_PER_SEC - 1);

    err_mask_t         sys_mask;
    err_mask_t         ing_miss;
    err_mask_t         hold_mask;
    logic [TICK_W-1:0] tick_cnt;
    logic [HOLD_W-1:0] secs_left;
    logic              start_ok;
    logic              refused;
    logic              sel_press;

    // ====================
    // System faults
    // ====================
    always_comb begin
        sys_mask = '0;
        if (sensors.paper_level == 2'b00)
            sys_mask[ERR_PAPER_NOT_INST] = 1'b1;
        else if (sensors.paper_level == 2'b01)
            sys_mask[ERR_PAPER_EMPTY] = 1'b1;
        if (sensors.pressure == 2'b11)
            sys_mask[ERR_PRESS_FAULT] = 1'b1;
        else if (sensors.pressure == 2'b10)
            sys_mask[ERR_PRESS_HIGH] = 1'b1;
        sys_mask[ERR_STATUS_BAD] = ~sensors.status;
    end

    // Ingredients the live recipe needs but cannot get
    always_comb begin
        ing_miss = '0;
        if (recipe.grinder_time != 4'd0) begin
            ing_miss[ERR_NO_COFFEE0] = ~sel.flavor & sensors.bin0_empty;
            ing_miss[ERR_NO_COFFEE1] = sel.flavor & sensors.bin1_empty;
        end
        ing_miss[ERR_NO_CHOC]    = (recipe.cocoa_time != 4'd0) & sensors.choc_empty;
        ing_miss[ERR_NO_CREAMER] = recipe.add_creamer & sensors.creamer_empty;
    end

    assign sys_fault   = |sys_mask;
    assign start_ok    = presses.start & ~busy & ~sys_fault;
    assign start_grant = start_ok & (ing_miss == '0);
    assign refused     = start_ok & (ing_miss != '0);
    assign sel_press   = presses.flavor | presses.drink_type | presses.size;

    // ====================
    // Ingredient error hold
    // ====================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_mask <= '0;
            tick_cnt  <= '0;
            secs_left <= '0;
        end else if (sys_fault || busy) begin
            hold_mask <= '0;
            tick_cnt  <= '0;
            secs_left <= '0;
        end else if (refused) begin
            hold_mask <= ing_miss;
            tick_cnt  <= '0;
            secs_left <= HOLD_W'(`COFFEE_ING_HOLD_SECS);
        end else if (sel_press) begin
            // New selection makes the old complaint stale
            hold_mask <= '0;
            tick_cnt  <= '0;
            secs_left <= '0;
        end else if (hold_mask != '0) begin
            if (tick_cnt == TICK_LAST) begin
                tick_cnt <= '0;
                if (secs_left <= HOLD_W'(1)) begin
                    hold_mask <= '0;
                    secs_left <= '0;
                end else begin
                    secs_left <= secs_left - 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign err_mask = sys_mask | hold_mask;

endmodule

//--- brew_sequencer.sv
`timescale 1ns/10ps
`include "coffee_params.svh"

module brew_sequencer
    import coffee_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start_grant,
    input  logic       sys_fault,
    input  logic       water_hot,
    input  selection_t sel,
    input  recipe_t    recipe,
    output sys_state_t state,
    output logic       busy,
    output phase_t     phase,
    output selection_t shown,
    output actuators_t act
);

    localparam int TICK_W = $clog2(`COFFEE_TICKS_PER_SEC + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`COFFEE_TICKS_PER_SEC - 1);

    recipe_t           recipe_lat;
    selection_t        sel_lat;
    logic [TICK_W-1:0] tick_cnt;
    logic [3:0]        sec_left;
    phase_t            first_p;
    phase_t            next_p;

    // ====================
    // Phase helpers
    // ====================
    function automatic logic [3:0] phase_dur(input phase_t p, input recipe_t r);
        case (p)
            PH_PAPER: return r.load_filter ? 4'd1 : 4'd0;
            PH_GRIND: return r.grinder_time;
            PH_COCOA: return r.cocoa_time;
            PH_POUR:  return r.pour_time;
            PH_WATER: return r.hot_water_time;
            default:  return 4'd0;
        endcase
    endfunction

    function automatic phase_t step_phase(input phase_t p);
        case (p)
            PH_PAPER: return PH_GRIND;
            PH_GRIND: return PH_COCOA;
            PH_COCOA: return PH_POUR;
            PH_POUR:  return PH_WATER;
            default:  return PH_DONE;
        endcase
    endfunction

    // First phase at or after p that has a nonzero duration
    function automatic phase_t first_active(input phase_t p, input recipe_t r);
        phase_t q;
        q = p;
        for (int k = 0; k < 5; k++) begin
            if (q != PH_DONE && phase_dur(q, r) == 4'd0)
                q = step_phase(q);
        end
        return q;
    endfunction

    always_comb begin
        first_p = first_active(PH_PAPER, recipe_lat);
        next_p  = first_active(step_phase(phase), recipe_lat);
    end

    // Recipe and selection captured on a granted start
    always_ff @(posedge clk) begin
        if (start_grant) begin
            recipe_lat <= recipe;
            sel_lat    <= sel;
        end
    end

    // ====================
    // State machine
    // ====================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_SELECT;
            phase    <= PH_PAPER;
            tick_cnt <= '0;
            sec_left <= 4'd0;
        end else if (sys_fault) begin
            state    <= ST_SELECT;
            phase    <= PH_PAPER;
            tick_cnt <= '0;
            sec_left <= 4'd0;
        end else begin
            case (state)
                ST_SELECT: begin
                    if (start_grant)
                        state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (water_hot) begin
                        state    <= ST_BREW;
                        phase    <= first_p;
                        sec_left <= phase_dur(first_p, recipe_lat);
                        tick_cnt <= '0;
                    end
                end
                ST_BREW: begin
                    if (phase == PH_DONE) begin
                        state <= ST_SELECT;
                        phase <= PH_PAPER;
                    end else if (tick_cnt == TICK_LAST) begin
                        tick_cnt <= '0;
                        // Last second of this phase ends, move on
                        if (sec_left <= 4'd1) begin
                            phase    <= next_p;
                            sec_left <= phase_dur(next_p, recipe_lat);
                        end else begin
                            sec_left <= sec_left - 4'd1;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= ST_SELECT;
            endcase
        end
    end

    assign busy  = (state != ST_SELECT);
    assign shown = busy ? sel_lat : sel;

    // ====================
    // Actuator enables
    // ====================
    always_comb begin
        act = '0;
        if (!sys_fault) begin
            act.heat = busy & ~water_hot;
            if (state == ST_BREW) begin
                if (sec_left != 4'd0) begin
                    case (phase)
                        PH_PAPER: act.paper = 1'b1;
                        PH_GRIND: begin
                            act.grinder0 = ~sel_lat.flavor;
                            act.grinder1 = sel_lat.flavor;
                        end
                        PH_COCOA: act.cocoa = 1'b1;
                        PH_POUR:  act.pourover = 1'b1;
                        PH_WATER: act.water = 1'b1;
                        default:  act.paper = 1'b0;
                    endcase
                end
                act.creamer = recipe_lat.add_creamer;
            end
        end
    end

endmodule

//--- coffee_machine.sv
`timescale 1ns/10ps

module coffee_machine
    import coffee_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  buttons_t   buttons,
    input  sensors_t   sensors,
    output selection_t shown,
    output sys_state_t state,
    output phase_t     phase,
    output actuators_t act,
    output err_mask_t  err_mask
);

    buttons_t   presses;
    selection_t sel;
    recipe_t    recipe;
    logic       sys_fault;
    logic       start_grant;
    logic       busy;

    button_edges u_edges (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .presses (presses)
    );

    selection_ctrl u_select (
        .clk     (clk),
        .rst     (rst),
        .presses (presses),
        .busy    (busy),
        .sel     (sel),
        .recipe  (recipe)
    );

    fault_monitor u_faults (
        .clk         (clk),
        .rst         (rst),
        .sensors     (sensors),
        .presses     (presses),
        .sel         (sel),
        .recipe      (recipe),
        .busy        (busy),
        .sys_fault   (sys_fault),
        .start_grant (start_grant),
        .err_mask    (err_mask)
    );

    brew_sequencer u_brew (
        .clk         (clk),
        .rst         (rst),
        .start_grant (start_grant),
        .sys_fault   (sys_fault),
        .water_hot   (sensors.temp_ready),
        .sel         (sel),
        .recipe      (recipe),
        .state       (state),
        .busy        (busy),
        .phase       (phase),
        .shown       (shown),
        .act         (act)
    );

endmodule

//--- coffee_machine_props.sv
`timescale 1ns/10ps

module coffee_machine_props
    import coffee_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input sys_state_t state,
    input actuators_t act,
    input err_mask_t  err_mask
);

    localparam err_mask_t SYS_BITS = err_mask_t'((1 << ERR_PAPER_NOT_INST) |
        (1 << ERR_PAPER_EMPTY) | (1 << ERR_PRESS_FAULT) | (1 << ERR_PRESS_HIGH) |
        (1 << ERR_STATUS_BAD));

    // Number of assertion failures seen so far
    int assert_fails = 0;

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        2'(state) != 2'b11)
        else begin
            $error("state holds the unused encoding");
            assert_fails++;
        end

    a_fault_quiet: assert property (@(posedge clk) disable iff (rst)
        ((err_mask & SYS_BITS) != '0) |-> (act == '0))
        else begin
            $error("actuator enabled during a system fault");
            assert_fails++;
        end

    a_one_phase: assert property (@(posedge clk) disable iff (rst)
        $onehot0({act.pourover, act.water, act.grinder0, act.grinder1, act.paper, act.cocoa}))
        else begin
            $error("more than one phase actuator enabled");
            assert_fails++;
        end

endmodule

//--- coffee_machine_tb.sv
`timescale 1ns/10ps
`include "coffee_params.svh"

module coffee_machine_tb
    import coffee_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int TPS         = `COFFEE_TICKS_PER_SEC;
    localparam int HOLD_CYCLES = `COFFEE_ING_HOLD_SECS * TPS;
    localparam int NUM_TESTS   = 40;
    localparam int TEST_CYCLES = 200;
    // Filter second plus four phases of up to 15 s and the done cycle
    localparam int MAX_BREW    = (1 + 4 * 15) * TPS + 2;
    localparam int WATCHDOG_NS = (NUM_TESTS * MAX_BREW + 500) * CLK_PERIOD;

    logic       clk;
    logic       rst;
    buttons_t   buttons;
    sensors_t   sensors;
    selection_t shown;
    sys_state_t state;
    phase_t     phase;
    actuators_t act;
    err_mask_t  err_mask;

    logic [$bits(recipe_t)-1:0] rec_table [`COFFEE_RECIPES];
    logic [31:0] lfsr;
    logic        fault_on;

    // Reference model state
    buttons_t    m_prev;
    logic        m_armed;
    selection_t  m_sel;
    selection_t  m_sel_lat;
    recipe_t     m_rec_lat;
    sys_state_t  m_state;
    int          m_phase;
    int          m_left;
    err_mask_t   m_hold;
    int          m_hold_left;

    int n_err_sel;
    int n_err_state;
    int n_err_phase;
    int n_err_act;
    int n_err_mask;

    coffee_machine u_dut (
        .clk      (clk),
        .rst      (rst),
        .buttons  (buttons),
        .sensors  (sensors),
        .shown    (shown),
        .state    (state),
        .phase    (phase),
        .act      (act),
        .err_mask (err_mask)
    );

    bind coffee_machine coffee_machine_props u_props (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .act      (act),
        .err_mask (err_mask)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Random source
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic recipe_t lookup(input selection_t s);
        logic [3:0] idx;
        idx = 4'(int'(s.drink_type) * 3 + int'(s.size));
        return recipe_t'(rec_table[idx]);
    endfunction

    // Phase length in clock cycles for phases 0 to 4 in brew order
    function automatic int phase_cycles(input int p, input recipe_t r);
        case (p)
            0:       return r.load_filter ? TPS : 0;
            1:       return int'(r.grinder_time) * TPS;
            2:       return int'(r.cocoa_time) * TPS;
            3:       return int'(r.pour_time) * TPS;
            4:       return int'(r.hot_water_time) * TPS;
            default: return 0;
        endcase
    endfunction

    function automatic int next_phase(input int p, input recipe_t r);
        int q;
        q = p;
        while (q < 5 && phase_cycles(q, r) == 0)
            q++;
        return q;
    endfunction

    function automatic err_mask_t sys_faults(input sensors_t s);
        err_mask_t m;
        m = '0;
        case (s.paper_level)
            2'b00:   m[ERR_PAPER_NOT_INST] = 1'b1;
            2'b01:   m[ERR_PAPER_EMPTY] = 1'b1;
            default: ;
        endcase
        case (s.pressure)
            2'b11:   m[ERR_PRESS_FAULT] = 1'b1;
            2'b10:   m[ERR_PRESS_HIGH] = 1'b1;
            default: ;
        endcase
        if (!s.status)
            m[ERR_STATUS_BAD] = 1'b1;
        return m;
    endfunction

    function automatic err_mask_t missing(input sensors_t s, input selection_t sel,
                                          input recipe_t r);
        err_mask_t m;
        m = '0;
        if (r.grinder_time != 4'd0) begin
            if (sel.flavor)
                m[ERR_NO_COFFEE1] = s.bin1_empty;
            else
                m[ERR_NO_COFFEE0] = s.bin0_empty;
        end
        if (r.cocoa_time != 4'd0)
            m[ERR_NO_CHOC] = s.choc_empty;
        if (r.add_creamer)
            m[ERR_NO_CREAMER] = s.creamer_empty;
        return m;
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic compare_selection(input selection_t got, input selection_t exp);
        if (got !== exp) begin
            n_err_sel++;
            $display("error %0t: shown selection %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_state(input sys_state_t got, input sys_state_t exp);
        if (got !== exp) begin
            n_err_state++;
            $display("error %0t: state %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic compare_phase(input phase_t got, input phase_t exp);
        if (got !== exp) begin
            n_err_phase++;
            $display("error %0t: phase %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic compare_actuators(input actuators_t got, input actuators_t exp);
        if (got !== exp) begin
            n_err_act++;
            $display("error %0t: actuators %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic compare_err(input err_mask_t got, input err_mask_t exp);
        if (got !== exp) begin
            n_err_mask++;
            $display("error %0t: err_mask %h, expected %h", $time, got, exp);
        end
    endtask

    // Check this cycle's outputs and step the model to the next edge
    task automatic check_and_advance();
        buttons_t   pr;
        recipe_t    live;
        err_mask_t  sysm;
        err_mask_t  miss;
        logic       fault;
        logic       busy;
        logic       start_ok;
        actuators_t ea;

        pr       = m_armed ? buttons_t'(buttons & ~m_prev) : buttons_t'('0);
        live     = lookup(m_sel);
        sysm     = sys_faults(sensors);
        miss     = missing(sensors, m_sel, live);
        fault    = (sysm != '0);
        busy     = (m_state != ST_SELECT);
        start_ok = pr.start && !busy && !fault;

        ea = '0;
        if (!fault) begin
            ea.heat = busy && !sensors.temp_ready;
            if (m_state == ST_BREW) begin
                ea.creamer = m_rec_lat.add_creamer;
                case (m_phase)
                    0: ea.paper = 1'b1;
                    1: begin
                        ea.grinder0 = !m_sel_lat.flavor;
                        ea.grinder1 = m_sel_lat.flavor;
                    end
                    2: ea.cocoa = 1'b1;
                    3: ea.pourover = 1'b1;
                    4: ea.water = 1'b1;
                    default: ;
                endcase
            end
        end

        compare_selection(shown, busy ? m_sel_lat : m_sel);
        compare_state(state, m_state);
        if (m_state == ST_BREW)
            compare_phase(phase, phase_t'(m_phase));
        compare_actuators(act, ea);
        compare_err(err_mask, sysm | m_hold);

        m_prev  = buttons;
        m_armed = 1'b1;

        // Ingredient hold
        if (fault || busy) begin
            m_hold      = '0;
            m_hold_left = 0;
        end else if (start_ok && miss != '0) begin
            m_hold      = miss;
            m_hold_left = HOLD_CYCLES;
        end else if (pr.flavor || pr.drink_type || pr.size) begin
            m_hold      = '0;
            m_hold_left = 0;
        end else if (m_hold != '0) begin
            m_hold_left--;
            if (m_hold_left == 0)
                m_hold = '0;
        end

        // Brew state latches the selection before it steps
        if (fault) begin
            m_state = ST_SELECT;
        end else begin
            case (m_state)
                ST_SELECT: begin
                    if (start_ok && miss == '0) begin
                        m_state   = ST_WAIT;
                        m_rec_lat = live;
                        m_sel_lat = m_sel;
                    end
                end
                ST_WAIT: begin
                    if (sensors.temp_ready) begin
                        m_state = ST_BREW;
                        m_phase = next_phase(0, m_rec_lat);
                        m_left  = phase_cycles(m_phase, m_rec_lat);
                    end
                end
                ST_BREW: begin
                    if (m_phase == 5) begin
                        m_state = ST_SELECT;
                    end else begin
                        m_left--;
                        if (m_left == 0) begin
                            m_phase = next_phase(m_phase + 1, m_rec_lat);
                            m_left  = phase_cycles(m_phase, m_rec_lat);
                        end
                    end
                end
                default: m_state = ST_SELECT;
            endcase
        end

        if (!busy) begin
            if (pr.flavor)
                m_sel.flavor = !m_sel.flavor;
            if (pr.drink_type)
                m_sel.drink_type = 3'((int'(m_sel.drink_type) + 1) % 5);
            if (pr.size)
                m_sel.size = 2'((int'(m_sel.size) + 1) % 3);
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic drive_inputs(input logic quiet);
        logic [31:0] r;
        logic [31:0] b;

        // Buttons stay mostly released so that a nonzero level is usually a fresh press
        take_bits(quiet ? 6 : 3, r);
        if (r == 0) begin
            take_bits(4, b);
            buttons = buttons_t'(b[3:0]);
        end else begin
            buttons = '0;
        end

        take_bits(5, r);
        if (r == 0)
            sensors.temp_ready = ~sensors.temp_ready;

        take_bits(4, r);
        if (r == 0) begin
            take_bits(8, b);
            sensors.bin0_empty    = &b[1:0];
            sensors.bin1_empty    = &b[3:2];
            sensors.creamer_empty = &b[5:4];
            sensors.choc_empty    = &b[7:6];
        end

        // Rare fault episodes of a few cycles
        if (fault_on) begin
            take_bits(2, r);
            if (r == 0)
                fault_on = 1'b0;
        end else begin
            take_bits(8, r);
            if (r == 0)
                fault_on = 1'b1;
        end
        if (fault_on) begin
            take_bits(5, r);
            sensors.paper_level = r[1:0];
            sensors.pressure    = r[3:2];
            sensors.status      = r[4];
        end else begin
            take_bits(2, r);
            sensors.paper_level = {1'b1, r[0]};
            sensors.pressure    = {1'b0, r[1]};
            sensors.status      = 1'b1;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] mode;
        int          total;

        rst                 = 1'b1;
        buttons             = '0;
        sensors             = '0;
        sensors.paper_level = 2'b11;
        sensors.status      = 1'b1;
        fault_on            = 1'b0;
        lfsr                = 32'd75107;
        m_prev              = '0;
        m_armed             = 1'b0;
        m_sel               = '0;
        m_sel_lat           = '0;
        m_rec_lat           = '0;
        m_state             = ST_SELECT;
        m_phase             = 0;
        m_left              = 0;
        m_hold              = '0;
        m_hold_left         = 0;
        n_err_sel           = 0;
        n_err_state         = 0;
        n_err_phase         = 0;
        n_err_act           = 0;
        n_err_mask          = 0;
        $readmemh("recipes.hex", rec_table);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Each test is either busy with presses or quiet enough for holds to expire
        for (int t = 0; t < NUM_TESTS; t++) begin
            take_bits(1, mode);
            for (int c = 0; c < TEST_CYCLES; c++) begin
                drive_inputs(mode[0]);
                #1;
                check_and_advance();
                @(negedge clk);
            end
        end

        total = n_err_sel + n_err_state + n_err_phase + n_err_act + n_err_mask
              + u_dut.u_props.assert_fails;
        $display({"errors: selection %0d, state %0d, phase %0d, actuators %0d,",
                  " err_mask %0d, assertions %0d"},
                 n_err_sel, n_err_state, n_err_phase, n_err_act, n_err_mask,
                 u_dut.u_props.assert_fails);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- recipes.hex
// One recipe word per line, row = drink type * 3 + size
// Bits 17 load filter, 16:13 pour, 12:9 hot water, 8:5 grinder, 4:1 cocoa, 0 add creamer
22020
24220
26240
22221
24241
24441
22023
24223
24225
00202
00405
00607
00000
00400
00800

//--- coffee_machine.f
+incdir+.
coffee_pkg.sv
button_edges.sv
selection_ctrl.sv
fault_monitor.sv
brew_sequencer.sv
coffee_machine.sv
coffee_machine_props.sv
coffee_machine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= coffee_machine_tb
FILELIST  ?= coffee_machine.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
